// ==== logic/cache_pkg.sv ====
// shared sizes and address field widths for the data cache
// opcode enum plus the controller and splitter state enums

package cache_pkg;

  // address and data sizes
  localparam int ADDR_W     = 32;            // byte address width
  localparam int DATA_W     = 64;            // core data width

  // line geometry
  localparam int LINE_BYTES = 64;            // bytes per line
  localparam int LINE_W     = LINE_BYTES * 8; // 512 bit line
  localparam int BANK_BYTES = 16;            // bank size seen by splitter
  localparam int NUM_LINES  = 64;            // direct mapped, one way

  // address fields, tag takes whatever is left over
  localparam int OFFSET_W   = $clog2(LINE_BYTES);
  localparam int INDEX_W    = $clog2(NUM_LINES);
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cache_op_e;

  typedef enum logic [2:0] {
    ST_IDLE,                                 // wait for bank req
    ST_LOOKUP,                               // tag compare
    ST_WBACK,                                // dirty victim out
    ST_REFILL,                               // line in from memory
    ST_ACK                                   // one cycle bank ack
  } ctrl_state_e;

  typedef enum logic [1:0] {
    SP_IDLE,
    SP_FIRST,                                // first (or only) half
    SP_SECOND,                               // half in the next bank
    SP_DONE                                  // core ack held
  } split_state_e;

endpackage

// ==== logic/cache_split.sv ====
// cache_split: unaligned core access splitter
// turns one core access into one or two bank accesses and merges the read data

`timescale 1ns/1ps

module cache_split (
  input  logic                            clk,
  input  logic                            rst,
  // core side, four-phase req/ack
  input  logic                            i_core_req,
  input  cache_pkg::cache_op_e            i_core_op,
  input  logic [cache_pkg::ADDR_W-1:0]    i_core_addr,
  input  logic [cache_pkg::DATA_W-1:0]    i_core_wdata,
  input  logic [2:0]                      i_core_bytes,   // byte count minus 1
  output logic [cache_pkg::DATA_W-1:0]    o_core_rdata,
  output logic                            o_core_ack,
  // bank side, ack is a pulse
  output logic                            o_bank_req,
  output cache_pkg::cache_op_e            o_bank_op,
  output logic [cache_pkg::ADDR_W-1:0]    o_bank_addr,
  output logic [cache_pkg::DATA_W-1:0]    o_bank_wdata,
  output logic [2:0]                      o_bank_bytes,
  input  logic [cache_pkg::DATA_W-1:0]    i_bank_rdata,
  input  logic                            i_bank_ack
);

  cache_pkg::split_state_e             state;
  logic [3:0]                          addr_lo;         // offset inside the bank
  logic [4:0]                          lo_end;          // offset of the last byte
  logic                                crossing;        // needs a second half
  logic [2:0]                          first_bytes;
  logic [2:0]                          second_bytes;
  logic [3:0]                          first_len;       // first half length in bytes
  logic [cache_pkg::ADDR_W-1:0]        second_addr;
  logic [cache_pkg::DATA_W-1:0]        second_wdata;
  logic [cache_pkg::DATA_W-1:0]        first_mask;
  logic [cache_pkg::DATA_W-1:0]        first_rdata;     // held result of first half
  logic [cache_pkg::DATA_W-1:0]        merged_rdata;
  logic                                in_second;

  assign addr_lo      = i_core_addr[3:0];
  assign lo_end       = {1'b0, addr_lo} + {2'b00, i_core_bytes};
  assign crossing     = lo_end >= 5'(cache_pkg::BANK_BYTES);

  // first half runs up to the bank end, second half gets the rest
  assign first_bytes  = crossing ? 3'(cache_pkg::BANK_BYTES - 1 - addr_lo) : i_core_bytes;
  assign second_bytes = 3'(lo_end - 5'(cache_pkg::BANK_BYTES));
  assign first_len    = {1'b0, first_bytes} + 4'd1;
  assign second_addr  = {i_core_addr[cache_pkg::ADDR_W-1:4] + 1'b1, 4'b0000};
  assign second_wdata = i_core_wdata >> {first_len, 3'b000};

  // low first_len bytes come from the first half
  assign first_mask   = (64'd1 << {first_len, 3'b000}) - 64'd1;
  assign merged_rdata = (first_rdata & first_mask) | (i_bank_rdata << {first_len, 3'b000});

  assign in_second    = (state == cache_pkg::SP_SECOND);

  assign o_bank_op    = i_core_op;                     // core holds op until ack
  assign o_bank_addr  = in_second ? second_addr  : i_core_addr;
  assign o_bank_wdata = in_second ? second_wdata : i_core_wdata;
  assign o_bank_bytes = in_second ? second_bytes : first_bytes;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= cache_pkg::SP_IDLE;
      o_bank_req <= 1'b0;
      o_core_ack <= 1'b0;
    end else begin
      case (state)
        cache_pkg::SP_IDLE: begin
          if (i_core_req) begin
            o_bank_req <= 1'b1;
            state      <= cache_pkg::SP_FIRST;
          end
        end
        cache_pkg::SP_FIRST: begin
          if (i_bank_ack) begin
            o_bank_req <= 1'b0;                         // drop req after ack pulse
            if (crossing) begin
              state <= cache_pkg::SP_SECOND;
            end else begin
              o_core_ack <= 1'b1;
              state      <= cache_pkg::SP_DONE;
            end
          end
        end
        cache_pkg::SP_SECOND: begin
          if (i_bank_ack) begin
            o_bank_req <= 1'b0;
            o_core_ack <= 1'b1;
            state      <= cache_pkg::SP_DONE;
          end else if (!o_bank_req) begin
            o_bank_req <= 1'b1;                         // req was low for one cycle
          end
        end
        cache_pkg::SP_DONE: begin
          if (!i_core_req) begin
            o_core_ack <= 1'b0;
            state      <= cache_pkg::SP_IDLE;
          end
        end
        default: state <= cache_pkg::SP_IDLE;
      endcase
    end
  end

  // read data path
  always_ff @(posedge clk) begin
    if (i_bank_ack && state == cache_pkg::SP_FIRST) begin
      first_rdata  <= i_bank_rdata;
      o_core_rdata <= i_bank_rdata;                   // final when not crossing
    end else if (i_bank_ack && in_second) begin
      o_core_rdata <= merged_rdata;
    end
  end

endmodule

// ==== logic/cache_ctrl.sv ====
// cache_ctrl: direct mapped write-back cache controller
// lookup, dirty writeback and refill FSM, byte extract and insert within a line

`timescale 1ns/1ps

module cache_ctrl (
  input  logic                              clk,
  input  logic                              rst,
  // bank side from the splitter
  input  logic                              i_bank_req,
  input  cache_pkg::cache_op_e              i_bank_op,
  input  logic [cache_pkg::ADDR_W-1:0]      i_bank_addr,
  input  logic [cache_pkg::DATA_W-1:0]      i_bank_wdata,
  input  logic [2:0]                        i_bank_bytes,
  output logic [cache_pkg::DATA_W-1:0]      o_bank_rdata,
  output logic                              o_bank_ack,
  // line store
  output logic [cache_pkg::INDEX_W-1:0]     o_st_rd_index,
  output logic                              o_st_wr_en,
  output logic [cache_pkg::INDEX_W-1:0]     o_st_wr_index,
  output logic [cache_pkg::TAG_W-1:0]       o_st_wr_tag,
  output logic                              o_st_wr_valid,
  output logic                              o_st_wr_dirty,
  output logic [cache_pkg::LINE_W-1:0]      o_st_wr_line,
  input  logic [cache_pkg::TAG_W-1:0]       i_st_rd_tag,
  input  logic                              i_st_rd_valid,
  input  logic                              i_st_rd_dirty,
  input  logic [cache_pkg::LINE_W-1:0]      i_st_rd_line,
  // memory, one line per transfer
  output logic                              o_mem_valid,
  output cache_pkg::cache_op_e              o_mem_op,
  output logic [cache_pkg::ADDR_W-1:0]      o_mem_addr,
  output logic [cache_pkg::LINE_W-1:0]      o_mem_wdata,
  input  logic                              i_mem_ready,
  input  logic [cache_pkg::LINE_W-1:0]      i_mem_rdata
);

  cache_pkg::ctrl_state_e                state;
  logic                                  armed;        // req seen low since last accept
  logic [cache_pkg::TAG_W-1:0]           req_tag;
  logic [cache_pkg::INDEX_W-1:0]         req_index;
  logic [cache_pkg::OFFSET_W-1:0]        req_off;
  logic                                  hit;
  logic [cache_pkg::LINE_W-1:0]          rd_shift;
  logic [cache_pkg::LINE_W-1:0]          ins_line;
  logic                                  hit_write;
  logic                                  refill_done;

  // address fields, all held steady by the splitter until ack
  assign req_tag   = i_bank_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
  assign req_index = i_bank_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
  assign req_off   = i_bank_addr[cache_pkg::OFFSET_W-1:0];

  assign hit       = i_st_rd_valid && (i_st_rd_tag == req_tag);

  // read bytes right aligned from the addressed offset
  assign rd_shift  = i_st_rd_line >> {req_off, 3'b000};

  // merge write bytes into the current line
  always_comb begin
    ins_line = i_st_rd_line;
    for (int b = 0; b < 8; b++) begin
      if (b <= int'(i_bank_bytes)) begin
        ins_line[(int'(req_off) + b) * 8 +: 8] = i_bank_wdata[b * 8 +: 8];
      end
    end
  end

  assign hit_write   = (state == cache_pkg::ST_LOOKUP) && hit &&
                       (i_bank_op == cache_pkg::OP_WRITE);
  assign refill_done = (state == cache_pkg::ST_REFILL) && i_mem_ready;

  // store ports, only one line is touched per request
  assign o_st_rd_index = req_index;
  assign o_st_wr_index = req_index;
  assign o_st_wr_en    = hit_write || refill_done;
  assign o_st_wr_tag   = req_tag;
  assign o_st_wr_valid = 1'b1;
  assign o_st_wr_dirty = hit_write;                   // refilled line starts clean
  assign o_st_wr_line  = refill_done ? i_mem_rdata : ins_line;

  // memory port, fields come from held state so they stay put under back-pressure
  assign o_mem_valid = (state == cache_pkg::ST_WBACK) || (state == cache_pkg::ST_REFILL);
  assign o_mem_op    = (state == cache_pkg::ST_WBACK) ? cache_pkg::OP_WRITE
                                                      : cache_pkg::OP_READ;
  assign o_mem_addr  = (state == cache_pkg::ST_WBACK)
                       ? {i_st_rd_tag, req_index, cache_pkg::OFFSET_W'(0)}
                       : {req_tag, req_index, cache_pkg::OFFSET_W'(0)};
  assign o_mem_wdata = i_st_rd_line;                  // victim line, unchanged during wback

  assign o_bank_ack  = (state == cache_pkg::ST_ACK);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cache_pkg::ST_IDLE;
      armed <= 1'b0;
    end else begin
      if (!i_bank_req) begin
        armed <= 1'b1;
      end
      case (state)
        cache_pkg::ST_IDLE: begin
          if (i_bank_req && armed) begin
            armed <= 1'b0;
            state <= cache_pkg::ST_LOOKUP;            // store read issued this cycle
          end
        end
        cache_pkg::ST_LOOKUP: begin
          if (hit) begin
            state <= cache_pkg::ST_ACK;
          end else if (i_st_rd_valid && i_st_rd_dirty) begin
            state <= cache_pkg::ST_WBACK;
          end else begin
            state <= cache_pkg::ST_REFILL;
          end
        end
        cache_pkg::ST_WBACK: begin
          if (i_mem_ready) begin
            state <= cache_pkg::ST_REFILL;
          end
        end
        cache_pkg::ST_REFILL: begin
          if (i_mem_ready) begin
            state <= cache_pkg::ST_LOOKUP;            // rerun against new line
          end
        end
        cache_pkg::ST_ACK: state <= cache_pkg::ST_IDLE;
        default:           state <= cache_pkg::ST_IDLE;
      endcase
    end
  end

  // hit data, valid during the ack pulse
  always_ff @(posedge clk) begin
    if (state == cache_pkg::ST_LOOKUP && hit) begin
      o_bank_rdata <= rd_shift[cache_pkg::DATA_W-1:0];
    end
  end

endmodule

// ==== logic/cache_store.sv ====
// cache_store: tag, valid, dirty and data arrays for the direct mapped cache
// registered read port, one write port, write data forwarded on same index

`timescale 1ns/1ps

module cache_store (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [cache_pkg::INDEX_W-1:0]     i_rd_index,
  input  logic                              i_wr_en,
  input  logic [cache_pkg::INDEX_W-1:0]     i_wr_index,
  input  logic [cache_pkg::TAG_W-1:0]       i_wr_tag,
  input  logic                              i_wr_valid,
  input  logic                              i_wr_dirty,
  input  logic [cache_pkg::LINE_W-1:0]      i_wr_line,
  output logic [cache_pkg::TAG_W-1:0]       o_rd_tag,
  output logic                              o_rd_valid,
  output logic                              o_rd_dirty,
  output logic [cache_pkg::LINE_W-1:0]      o_rd_line
);

  logic [cache_pkg::TAG_W-1:0]    tag_mem  [cache_pkg::NUM_LINES];
  logic [cache_pkg::LINE_W-1:0]   line_mem [cache_pkg::NUM_LINES];
  logic [cache_pkg::NUM_LINES-1:0] valid_bits;
  logic [cache_pkg::NUM_LINES-1:0] dirty_bits;
  logic                           fwd;                // write hits the read index

  assign fwd = i_wr_en && (i_wr_index == i_rd_index);

  // tag and data arrays
  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      tag_mem[i_wr_index]  <= i_wr_tag;
      line_mem[i_wr_index] <= i_wr_line;
    end
    if (fwd) begin
      o_rd_tag  <= i_wr_tag;                          // refill seen on next lookup
      o_rd_line <= i_wr_line;
    end else begin
      o_rd_tag  <= tag_mem[i_rd_index];
      o_rd_line <= line_mem[i_rd_index];
    end
  end

  // status bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_bits <= '0;
      dirty_bits <= '0;
      o_rd_valid <= 1'b0;
      o_rd_dirty <= 1'b0;
    end else begin
      if (i_wr_en) begin
        valid_bits[i_wr_index] <= i_wr_valid;
        dirty_bits[i_wr_index] <= i_wr_dirty;
      end
      if (fwd) begin
        o_rd_valid <= i_wr_valid;
        o_rd_dirty <= i_wr_dirty;
      end else begin
        o_rd_valid <= valid_bits[i_rd_index];
        o_rd_dirty <= dirty_bits[i_rd_index];
      end
    end
  end

endmodule

// ==== logic/cache_top.sv ====
// cache_top: data cache front end
// splitter, controller and line store between the core and the memory port

`timescale 1ns/1ps

module cache_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              i_core_req,
  input  cache_pkg::cache_op_e              i_core_op,
  input  logic [cache_pkg::ADDR_W-1:0]      i_core_addr,
  input  logic [cache_pkg::DATA_W-1:0]      i_core_wdata,
  input  logic [2:0]                        i_core_bytes,
  output logic [cache_pkg::DATA_W-1:0]      o_core_rdata,
  output logic                              o_core_ack,
  output logic                              o_mem_valid,
  output cache_pkg::cache_op_e              o_mem_op,
  output logic [cache_pkg::ADDR_W-1:0]      o_mem_addr,
  output logic [cache_pkg::LINE_W-1:0]      o_mem_wdata,
  input  logic                              i_mem_ready,
  input  logic [cache_pkg::LINE_W-1:0]      i_mem_rdata
);

  // bank port
  logic                               bank_req;
  cache_pkg::cache_op_e               bank_op;
  logic [cache_pkg::ADDR_W-1:0]       bank_addr;
  logic [cache_pkg::DATA_W-1:0]       bank_wdata;
  logic [2:0]                         bank_bytes;
  logic [cache_pkg::DATA_W-1:0]       bank_rdata;
  logic                               bank_ack;

  // store port
  logic [cache_pkg::INDEX_W-1:0]      st_rd_index;
  logic                               st_wr_en;
  logic [cache_pkg::INDEX_W-1:0]      st_wr_index;
  logic [cache_pkg::TAG_W-1:0]        st_wr_tag;
  logic                               st_wr_valid;
  logic                               st_wr_dirty;
  logic [cache_pkg::LINE_W-1:0]       st_wr_line;
  logic [cache_pkg::TAG_W-1:0]        st_rd_tag;
  logic                               st_rd_valid;
  logic                               st_rd_dirty;
  logic [cache_pkg::LINE_W-1:0]       st_rd_line;

  cache_split split_i (
    .clk          (clk),
    .rst          (rst),
    .i_core_req   (i_core_req),
    .i_core_op    (i_core_op),
    .i_core_addr  (i_core_addr),
    .i_core_wdata (i_core_wdata),
    .i_core_bytes (i_core_bytes),
    .o_core_rdata (o_core_rdata),
    .o_core_ack   (o_core_ack),
    .o_bank_req   (bank_req),
    .o_bank_op    (bank_op),
    .o_bank_addr  (bank_addr),
    .o_bank_wdata (bank_wdata),
    .o_bank_bytes (bank_bytes),
    .i_bank_rdata (bank_rdata),
    .i_bank_ack   (bank_ack)
  );

  cache_ctrl ctrl_i (
    .clk           (clk),
    .rst           (rst),
    .i_bank_req    (bank_req),
    .i_bank_op     (bank_op),
    .i_bank_addr   (bank_addr),
    .i_bank_wdata  (bank_wdata),
    .i_bank_bytes  (bank_bytes),
    .o_bank_rdata  (bank_rdata),
    .o_bank_ack    (bank_ack),
    .o_st_rd_index (st_rd_index),
    .o_st_wr_en    (st_wr_en),
    .o_st_wr_index (st_wr_index),
    .o_st_wr_tag   (st_wr_tag),
    .o_st_wr_valid (st_wr_valid),
    .o_st_wr_dirty (st_wr_dirty),
    .o_st_wr_line  (st_wr_line),
    .i_st_rd_tag   (st_rd_tag),
    .i_st_rd_valid (st_rd_valid),
    .i_st_rd_dirty (st_rd_dirty),
    .i_st_rd_line  (st_rd_line),
    .o_mem_valid   (o_mem_valid),
    .o_mem_op      (o_mem_op),
    .o_mem_addr    (o_mem_addr),
    .o_mem_wdata   (o_mem_wdata),
    .i_mem_ready   (i_mem_ready),
    .i_mem_rdata   (i_mem_rdata)
  );

  cache_store store_i (
    .clk        (clk),
    .rst        (rst),
    .i_rd_index (st_rd_index),
    .i_wr_en    (st_wr_en),
    .i_wr_index (st_wr_index),
    .i_wr_tag   (st_wr_tag),
    .i_wr_valid (st_wr_valid),
    .i_wr_dirty (st_wr_dirty),
    .i_wr_line  (st_wr_line),
    .o_rd_tag   (st_rd_tag),
    .o_rd_valid (st_rd_valid),
    .o_rd_dirty (st_rd_dirty),
    .o_rd_line  (st_rd_line)
  );

endmodule

// ==== tb/mem_model.sv ====
// line-wide memory model behind a valid/ready port
// byte image with a fixed fill pattern, ready delayed by 0 to 3 random cycles

`timescale 1ns/1ps

module mem_model (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            i_valid,
  input  cache_pkg::cache_op_e            i_op,
  input  logic [cache_pkg::ADDR_W-1:0]    i_addr,
  input  logic [cache_pkg::LINE_W-1:0]    i_wdata,
  output logic                            o_ready,
  output logic [cache_pkg::LINE_W-1:0]    o_rdata
);

  localparam int MEM_BYTES = 16384;                   // covers the test window plus 4 KB alias
  localparam int AW        = $clog2(MEM_BYTES);

  logic [7:0]    image [MEM_BYTES];
  logic [1:0]    delay;                               // cycles to hold ready low
  logic [1:0]    waited;                              // cycles valid has been high
  logic [AW-1:0] base;

  assign base    = i_addr[AW-1:0];
  assign o_ready = i_valid && (waited == delay);

  // whole line read, valid in the cycle ready is high
  always_comb begin
    for (int b = 0; b < cache_pkg::LINE_BYTES; b++) begin
      o_rdata[b*8 +: 8] = image[base + AW'(b)];
    end
  end

  // every byte is the low address byte xor the next one
  initial begin
    for (int a = 0; a < MEM_BYTES; a++) begin
      image[AW'(a)] = 8'(a) ^ 8'(a >> 8);
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      waited <= 2'd0;
      delay  <= 2'($urandom);
    end else if (i_valid && o_ready) begin
      waited <= 2'd0;
      delay  <= 2'($urandom);                         // next transfer gets a fresh delay
      if (i_op == cache_pkg::OP_WRITE) begin
        for (int b = 0; b < cache_pkg::LINE_BYTES; b++) begin
          image[base + AW'(b)] <= i_wdata[b*8 +: 8];
        end
      end
    end else if (i_valid) begin
      waited <= waited + 2'd1;
    end
  end

endmodule

// ==== tb/tb_cache_top.sv ====
// testbench for the data cache front end
// clock, reset, directed and random accesses against a shadow byte image
// handshake checks on the core and memory ports, watchdog

`timescale 1ns/1ps

module tb_cache_top;

  localparam int          CLK_NS       = 4;
  localparam int          MEM_BYTES    = 16384;
  localparam logic [31:0] SEED         = 32'h7daa_9c27;
  localparam int          N_RANDOM     = 400;
  localparam int          N_ACCESS     = N_RANDOM + 60;  // directed accesses on top
  localparam int          WORST_CYCLES = 40;             // two halves, each with wback and refill
  localparam int          WATCHDOG_NS  = N_ACCESS * WORST_CYCLES * CLK_NS * 2;

  logic                 clk;
  logic                 rst;
  logic                 core_req;
  cache_pkg::cache_op_e core_op;
  logic [31:0]          core_addr;
  logic [63:0]          core_wdata;
  logic [2:0]           core_bytes;
  logic [63:0]          core_rdata;
  logic                 core_ack;
  logic                 mem_valid;
  cache_pkg::cache_op_e mem_op;
  logic [31:0]          mem_addr;
  logic [511:0]         mem_wdata;
  logic                 mem_ready;
  logic [511:0]         mem_rdata;

  logic [7:0]           shadow [MEM_BYTES];             // expected memory contents
  logic                 started;                        // first request issued
  logic                 prev_req;
  logic                 prev_ack;
  logic                 prev_valid;
  logic                 prev_ready;
  cache_pkg::cache_op_e prev_op;
  logic [31:0]          prev_addr;
  logic [511:0]         prev_wdata;

  cache_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .i_core_req   (core_req),
    .i_core_op    (core_op),
    .i_core_addr  (core_addr),
    .i_core_wdata (core_wdata),
    .i_core_bytes (core_bytes),
    .o_core_rdata (core_rdata),
    .o_core_ack   (core_ack),
    .o_mem_valid  (mem_valid),
    .o_mem_op     (mem_op),
    .o_mem_addr   (mem_addr),
    .o_mem_wdata  (mem_wdata),
    .i_mem_ready  (mem_ready),
    .i_mem_rdata  (mem_rdata)
  );

  mem_model mem_i (
    .clk     (clk),
    .rst     (rst),
    .i_valid (mem_valid),
    .i_op    (mem_op),
    .i_addr  (mem_addr),
    .i_wdata (mem_wdata),
    .o_ready (mem_ready),
    .o_rdata (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  function automatic logic [7:0] pattern_byte(input int a);
    return 8'(a) ^ 8'(a >> 8);
  endfunction

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic value_error(input string name, input string expected, input string actual);
    stop_run($sformatf("** Error at %0t: %s expected %s, got %s", $time, name, expected, actual));
  endtask

  // one core access, four-phase, called 1 ns after a rising edge
  task automatic do_access(input cache_pkg::cache_op_e op, input logic [31:0] addr,
                           input logic [63:0] wdata, input int nbytes);
    logic [63:0] expect_data;
    logic [63:0] mask;
    int          cycles;
    expect_data = '0;
    mask        = '0;
    cycles      = 0;
    for (int b = 0; b < nbytes; b++) begin
      expect_data[b*8 +: 8] = shadow[14'(int'(addr) + b)];
      mask[b*8 +: 8]        = 8'hff;
    end
    started    = 1'b1;
    core_req   = 1'b1;
    core_op    = op;
    core_addr  = addr;
    core_wdata = wdata;
    core_bytes = 3'(nbytes - 1);
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!core_ack && cycles < WORST_CYCLES);
    if (!core_ack) begin
      stop_run($sformatf("no o_core_ack within %0d cycles for address %h", WORST_CYCLES, addr));
    end
    if (op == cache_pkg::OP_READ) begin
      assert ((core_rdata & mask) == expect_data)
        else value_error("o_core_rdata", $sformatf("%h", expect_data),
                         $sformatf("%h", core_rdata & mask));
    end else begin
      for (int b = 0; b < nbytes; b++) begin
        shadow[14'(int'(addr) + b)] = wdata[b*8 +: 8];
      end
    end
    core_req = 1'b0;
    @(posedge clk);
    #1;
    @(posedge clk);                                   // ack falls one cycle after req
    #1;
  endtask

  // handshake rules, sampled mid-cycle where everything is settled
  always @(negedge clk) begin
    if (!rst) begin
      if (!started) begin
        assert (!core_ack) else stop_run("o_core_ack rose before the first request");
        assert (!mem_valid) else stop_run("o_mem_valid rose before the first request");
      end
      if (prev_ack && prev_req) begin
        assert (core_ack) else stop_run("o_core_ack fell while i_core_req was still high");
      end
      if (prev_ack && !prev_req) begin
        assert (!core_ack) else stop_run("o_core_ack stayed high after i_core_req fell");
      end
      if (prev_valid && !prev_ready) begin
        assert (mem_valid) else stop_run("o_mem_valid dropped before i_mem_ready");
        assert (mem_op == prev_op)
          else value_error("o_mem_op", $sformatf("%0d", prev_op), $sformatf("%0d", mem_op));
        assert (mem_addr == prev_addr)
          else value_error("o_mem_addr", $sformatf("%h", prev_addr), $sformatf("%h", mem_addr));
        if (prev_op == cache_pkg::OP_WRITE) begin
          assert (mem_wdata == prev_wdata)
            else value_error("o_mem_wdata", $sformatf("%h", prev_wdata),
                             $sformatf("%h", mem_wdata));
        end
      end
    end
    prev_req   = core_req;
    prev_ack   = core_ack;
    prev_valid = mem_valid;
    prev_ready = mem_ready;
    prev_op    = mem_op;
    prev_addr  = mem_addr;
    prev_wdata = mem_wdata;
  end

  initial begin
    #(WATCHDOG_NS);
    stop_run($sformatf("watchdog expired after %0d ns, an access never finished", WATCHDOG_NS));
  end

  initial begin
    void'($urandom(SEED));
    rst        = 1'b1;
    core_req   = 1'b0;
    core_op    = cache_pkg::OP_READ;
    core_addr  = '0;
    core_wdata = '0;
    core_bytes = '0;
    started    = 1'b0;
    for (int a = 0; a < MEM_BYTES; a++) begin
      shadow[14'(a)] = pattern_byte(a);
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (4) @(posedge clk);                        // idle, nothing may move
    #1;

    // aligned read, miss then hit
    do_access(cache_pkg::OP_READ, 32'h0100, 64'd0, 8);
    do_access(cache_pkg::OP_READ, 32'h0100, 64'd0, 8);

    // every write length, read back with neighbors
    for (int n = 1; n <= 8; n++) begin
      do_access(cache_pkg::OP_WRITE, 32'(32'h0200 + 16 * n + 4), {$urandom, $urandom}, n);
      do_access(cache_pkg::OP_READ, 32'(32'h0200 + 16 * n + 4), 64'd0, 8);
      do_access(cache_pkg::OP_READ, 32'(32'h0200 + 16 * n + 2), 64'd0, 8);
    end

    // bank crossing inside a line, start offsets 9 to 15
    for (int off = 9; off <= 15; off++) begin
      do_access(cache_pkg::OP_READ, 32'(32'h0310 + 64 * (off - 9) + off), 64'd0, 8);
      do_access(cache_pkg::OP_WRITE, 32'(32'h0310 + 64 * (off - 9) + off),
                {$urandom, $urandom}, 8);
      do_access(cache_pkg::OP_READ, 32'(32'h0310 + 64 * (off - 9) + off), 64'd0, 8);
    end

    // line crossing, both lines cold
    do_access(cache_pkg::OP_READ, 32'h0A3D, 64'd0, 8);
    do_access(cache_pkg::OP_WRITE, 32'h0B7E, {$urandom, $urandom}, 8);
    do_access(cache_pkg::OP_READ, 32'h0B7E, 64'd0, 8);

    // dirty eviction through an alias 4 KB away
    do_access(cache_pkg::OP_WRITE, 32'h0500, {$urandom, $urandom}, 8);
    do_access(cache_pkg::OP_READ, 32'h1500, 64'd0, 8);
    for (int b = 0; b < 8; b++) begin
      assert (mem_i.image[14'(32'h0500 + b)] == shadow[14'(32'h0500 + b)])
        else value_error("mem_i.image", $sformatf("%h", shadow[14'(32'h0500 + b)]),
                         $sformatf("%h", mem_i.image[14'(32'h0500 + b)]));
    end
    do_access(cache_pkg::OP_READ, 32'h0500, 64'd0, 8);

    // random ops, lengths and addresses in an 8 KB window
    for (int i = 0; i < N_RANDOM; i++) begin
      do_access(cache_pkg::cache_op_e'(1'($urandom)), $urandom % 8192,
                {$urandom, $urandom}, int'($urandom % 8) + 1);
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== compile.f ====
logic/cache_pkg.sv
logic/cache_split.sv
logic/cache_ctrl.sv
logic/cache_store.sv
logic/cache_top.sv
tb/mem_model.sv
tb/tb_cache_top.sv

// ==== Makefile ====
# Verilator flow for the data cache front end
# override any variable on the command line, e.g. make sim LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_cache_top
FLIST     ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "FAIL: see $(LOG)" && exit 1)
	@echo "PASS: see $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
